//--- logic/ps2_pkg.sv
package ps2_pkg;

        // one device frame and its status.
        typedef struct packed {
                logic [7:0] data;
                logic       frame_err;
                logic       parity_err;
        } ps2_rx_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // host to device commands
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        localparam logic [7:0] CMD_RESET   = 8'hff;
        localparam logic [7:0] CMD_ENABLE  = 8'hf4;
        localparam logic [7:0] CMD_SET_RES = 8'he8;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // device replies
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        localparam logic [7:0] RPL_ACK      = 8'hfa;
        localparam logic [7:0] RPL_SELFTEST = 8'haa;
        localparam logic [7:0] RPL_ID       = 8'h00;

        localparam logic [1:0] RES_DEFAULT = 2'd2;   // 4 counts per mm.

endpackage

//--- logic/mouse_pkg.sv
package mouse_pkg;

        localparam int POS_W = 12;

        // position of the always-one flag in the first byte.
        localparam int PKT_SYNC_BIT = 3;

        // three stream bytes, first byte in the low bits.
        typedef struct packed {
                logic [7:0] dy;
                logic [7:0] dx;
                logic       y_ovf;
                logic       x_ovf;
                logic       y_sign;
                logic       x_sign;
                logic       sync;
                logic       middle;
                logic       right;
                logic       left;
        } mouse_packet_t;

        typedef struct packed {
                logic [POS_W-1:0] x;
                logic [POS_W-1:0] y;
                logic [2:0]       buttons;  // middle, right, left.
        } mouse_position_t;

endpackage

//--- logic/ps2_rx.sv
module ps2_rx (
        input  logic             slowtick,
        input  logic             obf_set,
        input  logic             ps2_clk_i,
        input  logic             ps2_data_i,
        input  logic             tx_busy_i,
        output logic             rx_valid_o,
        output ps2_pkg::ps2_rx_t rx_o
);

        localparam int BIT_TIMEOUT = 200;

        logic [1:0] clk_s;
        logic [1:0] data_s;
        logic       clk_d;
        logic       fall_q;
        logic [3:0] bit_cnt;
        logic [7:0] to_cnt;
        logic [9:0] sh;
        logic       frame_end;

        assign frame_end = fall_q & (bit_cnt == 4'd10);

        always_ff @(posedge slowtick or posedge obf_set)
        begin
                if (obf_set)
                begin
                        clk_s      <= 2'b11;
                        data_s     <= 2'b11;
                        clk_d      <= 1'b1;
                        fall_q     <= 1'b0;
                        bit_cnt    <= 4'd0;
                        to_cnt     <= 8'd0;
                        rx_valid_o <= 1'b0;
                end
                else
                begin
                        clk_s      <= {clk_s[0], ps2_clk_i};
                        data_s     <= {data_s[0], ps2_data_i};
                        clk_d      <= clk_s[1];
                        fall_q     <= clk_d & ~clk_s[1] & ~tx_busy_i;
                        rx_valid_o <= frame_end & ~tx_busy_i;
                        if (tx_busy_i)
                                bit_cnt <= 4'd0;        // host owns the lines.
                        else if (fall_q)
                        begin
                                to_cnt  <= 8'd0;
                                bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
                        end
                        else if (bit_cnt != 4'd0)
                        begin
                                to_cnt <= to_cnt + 8'd1;
                                if (to_cnt == 8'(BIT_TIMEOUT - 1))
                                        bit_cnt <= 4'd0;        // stalled frame.
                        end
                end
        end

        // start, data lsb first, parity, then the stop bit read live.
        always_ff @(posedge slowtick)
        begin
                if (fall_q)
                        sh <= {data_s[1], sh[9:1]};
                if (frame_end)
                        rx_o <= '{data:       sh[8:1],
                                  frame_err:  sh[0] | ~data_s[1],
                                  parity_err: ~^sh[9:1]};
        end

endmodule

//--- logic/ps2_tx.sv
module ps2_tx (
        input  logic       slowtick,
        input  logic       obf_set,
        input  logic       ps2_clk_i,
        input  logic       ps2_data_i,
        input  logic       tx_start_i,
        input  logic [7:0] tx_byte_i,
        output logic       ps2_clk_oe_o,
        output logic       ps2_data_oe_o,
        output logic       tx_busy_o,
        output logic       tx_done_o,
        output logic       tx_nack_o
);

        localparam int INHIBIT_CYCLES = 100;
        localparam int INH_W = $clog2(INHIBIT_CYCLES);

        typedef enum logic [1:0] {TX_IDLE, TX_INHIBIT, TX_SHIFT} tx_state_t;

        tx_state_t        state;
        logic [1:0]       clk_s;
        logic [1:0]       data_s;
        logic             clk_d;
        logic             clk_fall;
        logic [INH_W-1:0] inh_cnt;
        logic [3:0]       bit_cnt;
        logic [9:0]       sh;

        assign clk_fall  = clk_d & ~clk_s[1];
        assign tx_busy_o = (state != TX_IDLE);

        always_ff @(posedge slowtick or posedge obf_set)
        begin
                if (obf_set)
                begin
                        state         <= TX_IDLE;
                        clk_s         <= 2'b11;
                        data_s        <= 2'b11;
                        clk_d         <= 1'b1;
                        inh_cnt       <= '0;
                        bit_cnt       <= 4'd0;
                        ps2_clk_oe_o  <= 1'b0;
                        ps2_data_oe_o <= 1'b0;
                        tx_done_o     <= 1'b0;
                        tx_nack_o     <= 1'b0;
                end
                else
                begin
                        clk_s     <= {clk_s[0], ps2_clk_i};
                        data_s    <= {data_s[0], ps2_data_i};
                        clk_d     <= clk_s[1];
                        tx_done_o <= 1'b0;
                        tx_nack_o <= 1'b0;
                        if (tx_start_i)
                        begin
                                state         <= TX_INHIBIT;    // also aborts a stuck send.
                                inh_cnt       <= '0;
                                bit_cnt       <= 4'd0;
                                ps2_clk_oe_o  <= 1'b1;
                                ps2_data_oe_o <= 1'b0;
                        end
                        else
                        begin
                                case (state)
                                TX_INHIBIT:
                                begin
                                        inh_cnt <= inh_cnt + INH_W'(1);
                                        if (inh_cnt == INH_W'(INHIBIT_CYCLES - 1))
                                        begin
                                                ps2_clk_oe_o  <= 1'b0;
                                                ps2_data_oe_o <= 1'b1;  // start bit.
                                                state         <= TX_SHIFT;
                                        end
                                end
                                TX_SHIFT:
                                begin
                                        if (clk_fall && bit_cnt == 4'd10)
                                        begin
                                                tx_done_o <= ~data_s[1];   // ack is low.
                                                tx_nack_o <= data_s[1];
                                                state     <= TX_IDLE;
                                        end
                                        else if (clk_fall)
                                        begin
                                                ps2_data_oe_o <= ~sh[0];
                                                bit_cnt       <= bit_cnt + 4'd1;
                                        end
                                end
                                default:
                                        state <= TX_IDLE;
                                endcase
                        end
                end
        end

        // data, odd parity, then a released stop bit.
        always_ff @(posedge slowtick)
        begin
                if (tx_start_i)
                        sh <= {1'b1, ~^tx_byte_i, tx_byte_i};
                else if (state == TX_SHIFT && clk_fall)
                        sh <= {1'b1, sh[9:1]};
        end

endmodule

//--- logic/mouse_controller.sv
module mouse_controller #(
        parameter int TIMEOUT_CYCLES = 4000
) (
        input  logic                     slowtick,
        input  logic                     obf_set,
        input  logic                     sens_btn_i,
        input  logic                     rx_valid_i,
        input  ps2_pkg::ps2_rx_t         rx_i,
        input  logic                     tx_done_i,
        input  logic                     tx_nack_i,
        output logic                     tx_start_o,
        output logic [7:0]               tx_byte_o,
        output logic                     packet_valid_o,
        output mouse_pkg::mouse_packet_t packet_o,
        output logic                     link_ready_o,
        output logic [1:0]               sens_o
);

        localparam int TO_W = $clog2(TIMEOUT_CYCLES);

        typedef enum logic [1:0] {S_SEND, S_WAIT_TX, S_REPLY, S_STREAM} state_t;

        state_t          state;
        logic [1:0]      step;          // reset, enable, set res, res value.
        logic [1:0]      rpl_idx;
        logic [1:0]      byte_cnt;
        logic [TO_W-1:0] to_cnt;
        logic [2:0]      btn_s;
        logic            sens_pend;
        logic [15:0]     pkt_buf;
        logic [7:0]      expect_rpl;
        logic            last_rpl;
        logic            rx_err;
        logic            timed_out;
        logic            byte_ok;
        logic            restart;

        always_comb
        begin
                case (step)
                2'd0:    tx_byte_o = ps2_pkg::CMD_RESET;
                2'd1:    tx_byte_o = ps2_pkg::CMD_ENABLE;
                2'd2:    tx_byte_o = ps2_pkg::CMD_SET_RES;
                default: tx_byte_o = {6'd0, sens_o};
                endcase
                if (step != 2'd0 || rpl_idx == 2'd0)
                        expect_rpl = ps2_pkg::RPL_ACK;
                else if (rpl_idx == 2'd1)
                        expect_rpl = ps2_pkg::RPL_SELFTEST;
                else
                        expect_rpl = ps2_pkg::RPL_ID;
        end

        assign last_rpl  = (step != 2'd0) || (rpl_idx == 2'd2);
        assign rx_err    = rx_i.frame_err | rx_i.parity_err;
        assign timed_out = (to_cnt == TO_W'(TIMEOUT_CYCLES - 1));
        assign byte_ok   = rx_valid_i & (state == S_STREAM) & ~rx_err &
                           ((byte_cnt != 2'd0) | rx_i.data[mouse_pkg::PKT_SYNC_BIT]);
        assign restart   = ((state == S_WAIT_TX) && (tx_nack_i || timed_out)) ||
                           ((state == S_REPLY) && (rx_valid_i ?
                                (rx_err || rx_i.data != expect_rpl) : timed_out));

        always_ff @(posedge slowtick or posedge obf_set)
        begin
                if (obf_set)
                begin
                        state          <= S_SEND;
                        step           <= 2'd0;
                        rpl_idx        <= 2'd0;
                        byte_cnt       <= 2'd0;
                        to_cnt         <= '0;
                        btn_s          <= 3'd0;
                        sens_pend      <= 1'b0;
                        sens_o         <= ps2_pkg::RES_DEFAULT;
                        tx_start_o     <= 1'b0;
                        packet_valid_o <= 1'b0;
                        link_ready_o   <= 1'b0;
                end
                else
                begin
                        btn_s          <= {btn_s[1:0], sens_btn_i};
                        tx_start_o     <= 1'b0;
                        packet_valid_o <= 1'b0;
                        to_cnt         <= (state == S_WAIT_TX || state == S_REPLY) ?
                                          to_cnt + TO_W'(1) : '0;
                        if (btn_s[2] & ~btn_s[1])
                                sens_pend <= 1'b1;      // release seen.
                        case (state)
                        S_SEND:
                        begin
                                tx_start_o <= 1'b1;
                                rpl_idx    <= 2'd0;
                                state      <= S_WAIT_TX;
                        end
                        S_WAIT_TX:
                        begin
                                if (tx_done_i)
                                begin
                                        to_cnt <= '0;
                                        state  <= S_REPLY;
                                end
                        end
                        S_REPLY:
                        begin
                                if (rx_valid_i)
                                        to_cnt <= '0;
                                if (rx_valid_i && !last_rpl)
                                        rpl_idx <= rpl_idx + 2'd1;
                                else if (rx_valid_i && step == 2'd3)
                                begin
                                        byte_cnt     <= 2'd0;
                                        link_ready_o <= 1'b1;
                                        state        <= S_STREAM;
                                end
                                else if (rx_valid_i)
                                begin
                                        step  <= step + 2'd1;
                                        state <= S_SEND;
                                end
                        end
                        default:
                        begin
                                if (rx_valid_i)
                                        byte_cnt <= (!byte_ok || byte_cnt == 2'd2) ?
                                                    2'd0 : byte_cnt + 2'd1;
                                else if (sens_pend && byte_cnt == 2'd0)
                                begin
                                        sens_pend    <= 1'b0;
                                        sens_o       <= sens_o + 2'd1;
                                        step         <= 2'd2;   // resend resolution only.
                                        link_ready_o <= 1'b0;
                                        state        <= S_SEND;
                                end
                                packet_valid_o <= byte_ok && byte_cnt == 2'd2;
                        end
                        endcase
                        if (restart)
                        begin
                                step         <= 2'd0;
                                link_ready_o <= 1'b0;
                                state        <= S_SEND;
                        end
                end
        end

        always_ff @(posedge slowtick)
        begin
                if (byte_ok)
                begin
                        case (byte_cnt)
                        2'd0:    pkt_buf[7:0]  <= rx_i.data;
                        2'd1:    pkt_buf[15:8] <= rx_i.data;
                        default: packet_o <= mouse_pkg::mouse_packet_t'({rx_i.data, pkt_buf});
                        endcase
                end
        end

endmodule

//--- logic/mouse_position.sv
module mouse_position #(
        parameter int SCREEN_W = 640,
        parameter int SCREEN_H = 480
) (
        input  logic                       slowtick,
        input  logic                       obf_set,
        input  logic                       packet_valid_i,
        input  mouse_pkg::mouse_packet_t   packet_i,
        output logic                       position_valid_o,
        output mouse_pkg::mouse_position_t position_o
);

        localparam int W = mouse_pkg::POS_W;

        logic signed [8:0]   dx;
        logic signed [8:0]   dy;
        logic signed [W+1:0] x_sum;
        logic signed [W+1:0] y_sum;

        function automatic logic [W-1:0] clamp(input logic signed [W+1:0] v, input int lim);
                if (v < 0)
                        return '0;
                else if (v > lim - 1)
                        return W'(lim - 1);
                else
                        return v[W-1:0];
        endfunction

        always_comb
        begin
                dx    = packet_i.x_ovf ? 9'sd0 : {packet_i.x_sign, packet_i.dx};
                dy    = packet_i.y_ovf ? 9'sd0 : {packet_i.y_sign, packet_i.dy};
                x_sum = $signed({2'b00, position_o.x}) + dx;
                y_sum = $signed({2'b00, position_o.y}) - dy;  // screen y grows downward.
        end

        always_ff @(posedge slowtick or posedge obf_set)
        begin
                if (obf_set)
                begin
                        position_valid_o <= 1'b0;
                        position_o       <= '0;
                end
                else
                begin
                        position_valid_o <= packet_valid_i;
                        if (packet_valid_i)
                        begin
                                position_o.x       <= clamp(x_sum, SCREEN_W);
                                position_o.y       <= clamp(y_sum, SCREEN_H);
                                position_o.buttons <= {packet_i.middle, packet_i.right,
                                                       packet_i.left};
                        end
                end
        end

endmodule

//--- logic/mouse_top.sv
module mouse_top #(
        parameter int SCREEN_W       = 640,
        parameter int SCREEN_H       = 480,
        parameter int TIMEOUT_CYCLES = 4000
) (
        input  logic                       slowtick,
        input  logic                       obf_set,
        input  logic                       sens_btn_i,
        input  logic                       ps2_clk_i,
        input  logic                       ps2_data_i,
        output logic                       ps2_clk_oe_o,
        output logic                       ps2_data_oe_o,
        output logic                       packet_valid_o,
        output mouse_pkg::mouse_packet_t   packet_o,
        output logic                       position_valid_o,
        output mouse_pkg::mouse_position_t position_o,
        output logic                       link_ready_o,
        output logic [1:0]                 sens_o
);

        logic             rx_valid;
        ps2_pkg::ps2_rx_t rx;
        logic             tx_start;
        logic [7:0]       tx_byte;
        logic             tx_busy;
        logic             tx_done;
        logic             tx_nack;

        ps2_rx u_rx (
                .slowtick, .obf_set, .ps2_clk_i, .ps2_data_i,
                .tx_busy_i (tx_busy),
                .rx_valid_o(rx_valid),
                .rx_o      (rx)
        );

        ps2_tx u_tx (
                .slowtick, .obf_set, .ps2_clk_i, .ps2_data_i,
                .tx_start_i(tx_start),
                .tx_byte_i (tx_byte),
                .ps2_clk_oe_o, .ps2_data_oe_o,
                .tx_busy_o (tx_busy),
                .tx_done_o (tx_done),
                .tx_nack_o (tx_nack)
        );

        mouse_controller #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_ctrl (
                .slowtick, .obf_set, .sens_btn_i,
                .rx_valid_i(rx_valid),
                .rx_i      (rx),
                .tx_done_i (tx_done),
                .tx_nack_i (tx_nack),
                .tx_start_o(tx_start),
                .tx_byte_o (tx_byte),
                .packet_valid_o, .packet_o, .link_ready_o, .sens_o
        );

        mouse_position #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_pos (
                .slowtick, .obf_set,
                .packet_valid_i(packet_valid_o),
                .packet_i      (packet_o),
                .position_valid_o, .position_o
        );

endmodule

//--- testbench/ps2_device_model.sv
module ps2_device_model #(
        parameter int HALF_CYCLES = 8,
        parameter int GAP_CYCLES  = 24
) (
        input  logic slowtick,
        input  logic ps2_clk_i,
        input  logic ps2_data_i,
        output logic clk_oe_o,
        output logic data_oe_o
);

        initial
        begin
                clk_oe_o  = 1'b0;
                data_oe_o = 1'b0;
        end

        task automatic wait_cycles(input int n);
                repeat (n) @(negedge slowtick);
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // device to host frame
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic send_frame(input logic [7:0] b, input logic bad_parity);
                logic [10:0] bits;
                int          i;
                bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};   // stop, parity, data, start.
                for (i = 0; i < 11; i++)
                begin
                        data_oe_o = ~bits[i];
                        wait_cycles(HALF_CYCLES);
                        clk_oe_o = 1'b1;
                        wait_cycles(HALF_CYCLES);
                        clk_oe_o = 1'b0;
                end
                data_oe_o = 1'b0;
                wait_cycles(GAP_CYCLES);
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // host to device frame
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic recv_frame(output logic [7:0] b, output logic frame_bad);
                logic [9:0] bits;
                int         i;
                bits = '0;
                do
                        @(negedge slowtick);
                while (ps2_clk_i !== 1'b0);                     // host inhibit.
                do
                        @(negedge slowtick);
                while (!(ps2_clk_i === 1'b1 && ps2_data_i === 1'b0));   // request to send.
                wait_cycles(HALF_CYCLES);
                for (i = 0; i < 10; i++)
                begin
                        clk_oe_o = 1'b1;
                        wait_cycles(HALF_CYCLES);
                        bits[i]  = ps2_data_i;                  // read before the rising edge.
                        clk_oe_o = 1'b0;
                        wait_cycles(HALF_CYCLES);
                end
                data_oe_o = 1'b1;                               // ack bit.
                wait_cycles(HALF_CYCLES);
                clk_oe_o = 1'b1;
                wait_cycles(HALF_CYCLES);
                clk_oe_o = 1'b0;
                wait_cycles(HALF_CYCLES);
                data_oe_o = 1'b0;
                frame_bad = (bits[8] != ~^bits[7:0]) || (bits[9] != 1'b1);
                b         = bits[7:0];
                wait_cycles(GAP_CYCLES);
        endtask

endmodule

//--- testbench/tb_mouse_top.sv
module tb_mouse_top;

        localparam int  SCREEN_W     = 640;
        localparam int  SCREEN_H     = 480;
        localparam int  NUM_FRAMES   = 700;
        localparam int  FRAME_CYCLES = 320;     // 11 bits, gap and host inhibit.
        localparam time WATCHDOG     = (NUM_FRAMES * FRAME_CYCLES + 5000) * 100;

        logic                       slowtick = 1'b0;
        logic                       obf_set;
        logic                       sens_btn_i;
        logic                       ps2_clk, ps2_data;
        logic                       dut_clk_oe, dut_data_oe, dev_clk_oe, dev_data_oe;
        logic                       packet_valid_o, position_valid_o, link_ready_o;
        mouse_pkg::mouse_packet_t   packet_o;
        mouse_pkg::mouse_position_t position_o;
        logic [1:0]                 sens_o;

        logic [31:0] lfsr = 32'h167bb7db;
        logic [23:0] pkt_q[$];
        logic [26:0] pos_q[$];
        int          errors = 0;
        int          pkt_count = 0;
        int          x_model, y_model;
        logic [1:0]  res_model;

        always #50 slowtick = ~slowtick;

        assign ps2_clk  = ~(dut_clk_oe | dev_clk_oe);   // open-drain wired-and.
        assign ps2_data = ~(dut_data_oe | dev_data_oe);

        mouse_top #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .TIMEOUT_CYCLES(4000)) u_dut (
                .slowtick, .obf_set, .sens_btn_i,
                .ps2_clk_i(ps2_clk), .ps2_data_i(ps2_data),
                .ps2_clk_oe_o(dut_clk_oe), .ps2_data_oe_o(dut_data_oe),
                .packet_valid_o, .packet_o, .position_valid_o, .position_o,
                .link_ready_o, .sens_o
        );

        ps2_device_model u_dev (
                .slowtick, .ps2_clk_i(ps2_clk), .ps2_data_i(ps2_data),
                .clk_oe_o(dev_clk_oe), .data_oe_o(dev_data_oe)
        );

        task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
                if (act !== exp)
                begin
                        errors++;
                        $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, act, exp);
                end
        endtask

        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                int          i;
                v = '0;
                for (i = 0; i < n; i++)
                begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
                        v    = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        function automatic int clamp_axis(input int v, input int lim);
                return (v < 0) ? 0 : (v > lim - 1) ? lim - 1 : v;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // strobe monitor, sampled mid-cycle
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always @(negedge slowtick)
        begin
                if (packet_valid_o)
                begin
                        pkt_count++;
                        if (pkt_q.size() == 0)
                        begin
                                errors++;
                                $display("unexpected packet strobe at %0t", $time);
                        end
                        else
                                check("packet_o", 32'(packet_o), 32'(pkt_q.pop_front()));
                end
                if (position_valid_o)
                begin
                        if (pos_q.size() == 0)
                        begin
                                errors++;
                                $display("unexpected position strobe at %0t", $time);
                        end
                        else
                                check("position_o", 32'(position_o), 32'(pos_q.pop_front()));
                end
        end

        task automatic apply_reset();
                @(negedge slowtick);
                obf_set = 1'b1;
                repeat (4) @(negedge slowtick);
                x_model   = 0;
                y_model   = 0;
                res_model = 2'd2;
                pkt_count = 0;
                obf_set   = 1'b0;
        endtask

        task automatic expect_cmd(input logic [7:0] exp);
                logic [7:0] c;
                logic       frame_bad;
                u_dev.recv_frame(c, frame_bad);
                check("tx command", 32'(c), 32'(exp));
                if (frame_bad)
                begin
                        errors++;
                        $display("command frame at %0t had a bad parity or stop bit", $time);
                end
        endtask

        task automatic wait_link_ready();
                int n;
                for (n = 0; n < 100 && !link_ready_o; n++)
                        @(negedge slowtick);
                if (!link_ready_o)
                begin
                        errors++;
                        $display("link_ready_o never rose after the last acknowledge");
                end
        endtask

        task automatic start_up(input logic bad_selftest);
                expect_cmd(8'hff);
                u_dev.send_frame(8'hfa, 1'b0);
                if (bad_selftest)
                begin
                        u_dev.send_frame(8'hfc, 1'b0);          // wrong self-test code.
                        expect_cmd(8'hff);
                        u_dev.send_frame(8'hfa, 1'b0);
                end
                u_dev.send_frame(8'haa, 1'b0);
                u_dev.send_frame(8'h00, 1'b0);
                expect_cmd(8'hf4);
                u_dev.send_frame(8'hfa, 1'b0);
                expect_cmd(8'he8);
                u_dev.send_frame(8'hfa, 1'b0);
                expect_cmd({6'd0, res_model});
                check("link_ready_o", 32'(link_ready_o), 32'd0);
                u_dev.send_frame(8'hfa, 1'b0);
                wait_link_ready();
                check("packet strobes before link ready", pkt_count, 0);
        endtask

        task automatic send_packet(input logic [7:0] b0, input logic [7:0] b1,
                                   input logic [7:0] b2);
                int dxs, dys;
                dxs     = b0[6] ? 0 : (b0[4] ? int'(b1) - 256 : int'(b1));
                dys     = b0[7] ? 0 : (b0[5] ? int'(b2) - 256 : int'(b2));
                x_model = clamp_axis(x_model + dxs, SCREEN_W);
                y_model = clamp_axis(y_model - dys, SCREEN_H);  // ps2 y points up.
                pkt_q.push_back({b2, b1, b0});
                pos_q.push_back({12'(x_model), 12'(y_model), b0[2:0]});
                u_dev.send_frame(b0, 1'b0);
                u_dev.send_frame(b1, 1'b0);
                u_dev.send_frame(b2, 1'b0);
        endtask

        task automatic random_packet(input logic [1:0] dir);
                logic [7:0] b1, b2;
                logic [2:0] btn;
                logic       x_ovf, y_ovf;
                b1    = 8'(take_bits(8));
                b2    = 8'(take_bits(8));
                btn   = 3'(take_bits(3));
                x_ovf = (take_bits(4) == 0);
                y_ovf = (take_bits(4) == 0);
                send_packet({y_ovf, x_ovf, dir[1], dir[0], 1'b1, btn}, b1, b2);
        endtask

        task automatic press_sens();
                @(negedge slowtick);
                sens_btn_i = 1'b1;
                repeat (10) @(negedge slowtick);
                sens_btn_i = 1'b0;
                res_model  = res_model + 2'd1;
                expect_cmd(8'he8);
                u_dev.send_frame(8'hfa, 1'b0);
                expect_cmd({6'd0, res_model});
                u_dev.send_frame(8'hfa, 1'b0);
                wait_link_ready();
                check("sens_o", 32'(sens_o), 32'(res_model));
        endtask

        initial
        begin
                #(WATCHDOG);
                $display("watchdog expired before the tests finished");
                $display("** FAIL **");
                $finish;
        end

        initial
        begin
                int i;
                obf_set    = 1'b1;
                sens_btn_i = 1'b0;
                apply_reset();
                start_up(1'b0);
                apply_reset();
                start_up(1'b1);
                for (i = 0; i < 200; i++)
                        random_packet(2'(i / 50));       // each quarter drives to a corner.
                // parity error in the second byte, third byte has no sync bit.
                u_dev.send_frame(8'h09, 1'b0);
                u_dev.send_frame(8'h22, 1'b1);
                u_dev.send_frame(8'h30, 1'b0);
                random_packet(2'd1);
                u_dev.send_frame(8'h00, 1'b0);          // first byte without sync.
                random_packet(2'd2);
                press_sens();
                random_packet(2'd0);
                press_sens();
                random_packet(2'd3);
                repeat (20) @(negedge slowtick);
                if (pkt_q.size() != 0 || pos_q.size() != 0)
                begin
                        errors++;
                        $display("%0d packets were sent but never reported", pkt_q.size());
                end
                $display("errors: %0d", errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

//--- mouse_top.f
logic/ps2_pkg.sv
logic/mouse_pkg.sv
logic/ps2_rx.sv
logic/ps2_tx.sv
logic/mouse_controller.sv
logic/mouse_position.sv
logic/mouse_top.sv
testbench/ps2_device_model.sv
testbench/tb_mouse_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PS/2 mouse host testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -f mouse_top.f --top-module tb_mouse_top -o sim_mouse

out=$(./obj_dir/sim_mouse)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
        exit 0
else
        exit 1
fi
